//--- logic/rs_dispatch.sv
// dispatch forwarding and allocation
module rs_dispatch
(
	rs_result_if.listen res,
	input rs_station_pkg::rs_mask_t free_mask,	// from the entry array

	input logic load_1,
	input rs_station_pkg::data_t opa_1,
	input rs_station_pkg::data_t opb_1,
	input logic opa_valid_1,
	input logic opb_valid_1,
	input rs_station_pkg::prf_tag_t dest_1,
	input rs_station_pkg::rob_idx_t rob_idx_1,
	input rs_station_pkg::op_type_t op_type_1,
	input rs_station_pkg::fu_kind_e kind_1,

	input logic load_2,
	input rs_station_pkg::data_t opa_2,
	input rs_station_pkg::data_t opb_2,
	input logic opa_valid_2,
	input logic opb_valid_2,
	input rs_station_pkg::prf_tag_t dest_2,
	input rs_station_pkg::rob_idx_t rob_idx_2,
	input rs_station_pkg::op_type_t op_type_2,
	input rs_station_pkg::fu_kind_e kind_2,

	output rs_station_pkg::rs_mask_t load_mask_1,	// one-hot or zero
	output rs_station_pkg::rs_mask_t load_mask_2,
	output rs_station_pkg::data_t fwd_opa_1,
	output rs_station_pkg::data_t fwd_opb_1,
	output rs_station_pkg::data_t fwd_opa_2,
	output rs_station_pkg::data_t fwd_opb_2,
	output logic fwd_opa_valid_1,
	output logic fwd_opb_valid_1,
	output logic fwd_opa_valid_2,
	output logic fwd_opb_valid_2,
	output rs_station_pkg::prf_tag_t ld_dest_1,
	output rs_station_pkg::rob_idx_t ld_rob_idx_1,
	output rs_station_pkg::op_type_t ld_op_type_1,
	output rs_station_pkg::fu_kind_e ld_kind_1,
	output rs_station_pkg::prf_tag_t ld_dest_2,
	output rs_station_pkg::rob_idx_t ld_rob_idx_2,
	output rs_station_pkg::op_type_t ld_op_type_2,
	output rs_station_pkg::fu_kind_e ld_kind_2,
	output logic rs_full,
	output logic rs_one_left
);

	rs_station_pkg::data_t [3:0] op_in;	// opa_1, opb_1, opa_2, opb_2
	rs_station_pkg::data_t [3:0] op_out;
	logic [3:0] vld_in;
	logic [3:0] vld_out;
	logic [3:0] hit1;
	logic [3:0] hit2;
	rs_station_pkg::rs_mask_t first_free;
	rs_station_pkg::rs_mask_t rest_free;
	rs_station_pkg::rs_mask_t second_free;

	assign op_in = {opb_2, opa_2, opb_1, opa_1};
	assign vld_in = {opb_valid_2, opa_valid_2, opb_valid_1, opa_valid_1};

	////////////////////////////////////////
	// same-cycle forwarding

	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			hit1[i] = res.res1_valid && (op_in[i][rs_station_pkg::PRF_TAG_W-1:0] == res.res1_tag);
			hit2[i] = res.res2_valid && (op_in[i][rs_station_pkg::PRF_TAG_W-1:0] == res.res2_tag);
			op_out[i] = op_in[i];
			vld_out[i] = vld_in[i];
			if (!vld_in[i] && hit1[i])
			begin
				op_out[i] = res.res1_data;
				vld_out[i] = 1'b1;
			end
			else if (!vld_in[i] && hit2[i])
			begin
				op_out[i] = res.res2_data;
				vld_out[i] = 1'b1;
			end
		end
	end

	assign fwd_opa_1 = op_out[0];
	assign fwd_opb_1 = op_out[1];
	assign fwd_opa_2 = op_out[2];
	assign fwd_opb_2 = op_out[3];
	assign fwd_opa_valid_1 = vld_out[0];
	assign fwd_opb_valid_1 = vld_out[1];
	assign fwd_opa_valid_2 = vld_out[2];
	assign fwd_opb_valid_2 = vld_out[3];

	// fields that need no forwarding go straight to the entries
	assign ld_dest_1 = dest_1;
	assign ld_rob_idx_1 = rob_idx_1;
	assign ld_op_type_1 = op_type_1;
	assign ld_kind_1 = kind_1;
	assign ld_dest_2 = dest_2;
	assign ld_rob_idx_2 = rob_idx_2;
	assign ld_op_type_2 = op_type_2;
	assign ld_kind_2 = kind_2;

	////////////////////////////////////////
	// slot allocation

	assign first_free = free_mask & (~free_mask + 1'b1);	// lowest set bit
	assign rest_free = free_mask & ~first_free;
	assign second_free = rest_free & (~rest_free + 1'b1);

	// slot 2 always takes the next-lowest, so it needs two free entries
	assign load_mask_1 = load_1 ? first_free : '0;
	assign load_mask_2 = load_2 ? second_free : '0;

	assign rs_full = (free_mask == '0);
	assign rs_one_left = (free_mask != '0) && (rest_free == '0);

endmodule

//--- logic/rs_entry_array.sv
// reservation station entry storage
module rs_entry_array
(
	input logic clock,
	input logic rst_n,
	rs_result_if.listen res,
	rs_issue_if.store iss,

	input rs_station_pkg::rs_mask_t load_mask_1,
	input rs_station_pkg::rs_mask_t load_mask_2,
	input rs_station_pkg::data_t fwd_opa_1,
	input rs_station_pkg::data_t fwd_opb_1,
	input rs_station_pkg::data_t fwd_opa_2,
	input rs_station_pkg::data_t fwd_opb_2,
	input logic fwd_opa_valid_1,
	input logic fwd_opb_valid_1,
	input logic fwd_opa_valid_2,
	input logic fwd_opb_valid_2,
	input rs_station_pkg::prf_tag_t dest_1,
	input rs_station_pkg::rob_idx_t rob_idx_1,
	input rs_station_pkg::op_type_t op_type_1,
	input rs_station_pkg::fu_kind_e kind_1,
	input rs_station_pkg::prf_tag_t dest_2,
	input rs_station_pkg::rob_idx_t rob_idx_2,
	input rs_station_pkg::op_type_t op_type_2,
	input rs_station_pkg::fu_kind_e kind_2,
	input logic flush_thread1,	// taken branch, thread 1
	input logic flush_thread2,

	output rs_station_pkg::rs_mask_t free_mask
);

	rs_station_pkg::rs_mask_t busy;
	rs_station_pkg::rs_mask_t opa_vld;
	rs_station_pkg::rs_mask_t opb_vld;
	rs_station_pkg::rs_mask_t flush_hit;
	rs_station_pkg::rs_mask_t a_hit1, a_hit2;
	rs_station_pkg::rs_mask_t b_hit1, b_hit2;
	rs_station_pkg::data_t [rs_station_pkg::RS_SIZE-1:0] opa_q;
	rs_station_pkg::data_t [rs_station_pkg::RS_SIZE-1:0] opb_q;
	rs_station_pkg::prf_tag_t [rs_station_pkg::RS_SIZE-1:0] dest_q;
	rs_station_pkg::rob_idx_t [rs_station_pkg::RS_SIZE-1:0] rob_idx_q;
	rs_station_pkg::op_type_t [rs_station_pkg::RS_SIZE-1:0] op_type_q;
	rs_station_pkg::fu_kind_e [rs_station_pkg::RS_SIZE-1:0] kind_q;

	////////////////////////////////////////
	// wakeup and flush matching

	always_comb
	begin
		for (int i = 0; i < rs_station_pkg::RS_SIZE; i++)
		begin
			a_hit1[i] = res.res1_valid && (opa_q[i][rs_station_pkg::PRF_TAG_W-1:0] == res.res1_tag);
			a_hit2[i] = res.res2_valid && (opa_q[i][rs_station_pkg::PRF_TAG_W-1:0] == res.res2_tag);
			b_hit1[i] = res.res1_valid && (opb_q[i][rs_station_pkg::PRF_TAG_W-1:0] == res.res1_tag);
			b_hit2[i] = res.res2_valid && (opb_q[i][rs_station_pkg::PRF_TAG_W-1:0] == res.res2_tag);
			// both flushes together hit every entry
			flush_hit[i] = rob_idx_q[i][rs_station_pkg::THREAD_BIT] ? flush_thread2 : flush_thread1;
		end
	end

	// a load wins over grant and flush, so dispatch during a flush is kept
	always_ff @(posedge clock)
	begin
		if (!rst_n)
			busy <= '0;
		else
		begin
			for (int i = 0; i < rs_station_pkg::RS_SIZE; i++)
			begin
				if (load_mask_1[i] || load_mask_2[i])
					busy[i] <= 1'b1;
				else if (iss.issue_grant[i] || flush_hit[i])
					busy[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		for (int i = 0; i < rs_station_pkg::RS_SIZE; i++)
		begin
			if (load_mask_1[i])
			begin
				opa_q[i] <= fwd_opa_1;
				opb_q[i] <= fwd_opb_1;
				opa_vld[i] <= fwd_opa_valid_1;
				opb_vld[i] <= fwd_opb_valid_1;
				dest_q[i] <= dest_1;
				rob_idx_q[i] <= rob_idx_1;
				op_type_q[i] <= op_type_1;
				kind_q[i] <= kind_1;
			end
			else if (load_mask_2[i])
			begin
				opa_q[i] <= fwd_opa_2;
				opb_q[i] <= fwd_opb_2;
				opa_vld[i] <= fwd_opa_valid_2;
				opb_vld[i] <= fwd_opb_valid_2;
				dest_q[i] <= dest_2;
				rob_idx_q[i] <= rob_idx_2;
				op_type_q[i] <= op_type_2;
				kind_q[i] <= kind_2;
			end
			else
			begin
				if (!opa_vld[i] && (a_hit1[i] || a_hit2[i]))
				begin
					opa_q[i] <= a_hit1[i] ? res.res1_data : res.res2_data;	// bus 1 first
					opa_vld[i] <= 1'b1;
				end
				if (!opb_vld[i] && (b_hit1[i] || b_hit2[i]))
				begin
					opb_q[i] <= b_hit1[i] ? res.res1_data : res.res2_data;
					opb_vld[i] <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// towards issue

	assign iss.ready = busy & opa_vld & opb_vld;
	assign iss.kind = kind_q;
	assign iss.opa = opa_q;
	assign iss.opb = opb_q;
	assign iss.dest = dest_q;
	assign iss.rob_idx = rob_idx_q;
	assign iss.op_type = op_type_q;

	assign free_mask = ~busy;

endmodule

//--- logic/rs_issue_select.sv
// issue port selection
module rs_issue_select
(
	rs_issue_if.select iss,
	input logic [rs_station_pkg::NUM_PORTS-1:0] fu_available,

	output logic [rs_station_pkg::NUM_PORTS-1:0] fu_out_valid,
	output rs_station_pkg::data_t [rs_station_pkg::NUM_PORTS-1:0] fu_opa,
	output rs_station_pkg::data_t [rs_station_pkg::NUM_PORTS-1:0] fu_opb,
	output rs_station_pkg::prf_tag_t [rs_station_pkg::NUM_PORTS-1:0] fu_dest,
	output rs_station_pkg::rob_idx_t [rs_station_pkg::NUM_PORTS-1:0] fu_rob_idx,
	output rs_station_pkg::op_type_t [rs_station_pkg::NUM_PORTS-1:0] fu_op_type
);

	rs_station_pkg::rs_mask_t is_mult;
	rs_station_pkg::rs_mask_t taken;	// entries already given to a port
	rs_station_pkg::rs_mask_t cand;
	rs_station_pkg::rs_mask_t pick;

	always_comb
	begin
		for (int e = 0; e < rs_station_pkg::RS_SIZE; e++)
			is_mult[e] = (iss.kind[e] == rs_station_pkg::FU_MULT);
	end

	////////////////////////////////////////
	// per-port pick, port 0 first

	always_comb
	begin
		taken = '0;
		cand = '0;
		pick = '0;
		fu_out_valid = '0;
		fu_opa = '0;	// fields stay zero on an idle port
		fu_opb = '0;
		fu_dest = '0;
		fu_rob_idx = '0;
		fu_op_type = '0;
		for (int p = 0; p < rs_station_pkg::NUM_PORTS; p++)
		begin
			// even ports are multipliers, odd ports adders
			cand = iss.ready & ~taken & ((p % 2 == 0) ? is_mult : ~is_mult);
			pick = cand & (~cand + 1'b1);
			if (fu_available[p] && (cand != '0))
			begin
				taken = taken | pick;
				fu_out_valid[p] = 1'b1;
				for (int e = 0; e < rs_station_pkg::RS_SIZE; e++)
				begin
					if (pick[e])
					begin
						fu_opa[p] = iss.opa[e];
						fu_opb[p] = iss.opb[e];
						fu_dest[p] = iss.dest[e];
						fu_rob_idx[p] = iss.rob_idx[e];
						fu_op_type[p] = iss.op_type[e];
					end
				end
			end
		end
	end

	assign iss.issue_grant = taken;	// frees the picked entries next edge

endmodule

//--- logic/rs_station.sv
// reservation station top
module rs_station
(
	input logic clock,
	input logic rst_n,

	input logic load_1,
	input rs_station_pkg::data_t opa_1,
	input rs_station_pkg::data_t opb_1,
	input logic opa_valid_1,
	input logic opb_valid_1,
	input rs_station_pkg::prf_tag_t dest_1,
	input rs_station_pkg::rob_idx_t rob_idx_1,
	input rs_station_pkg::op_type_t op_type_1,
	input rs_station_pkg::fu_kind_e kind_1,

	input logic load_2,
	input rs_station_pkg::data_t opa_2,
	input rs_station_pkg::data_t opb_2,
	input logic opa_valid_2,
	input logic opb_valid_2,
	input rs_station_pkg::prf_tag_t dest_2,
	input rs_station_pkg::rob_idx_t rob_idx_2,
	input rs_station_pkg::op_type_t op_type_2,
	input rs_station_pkg::fu_kind_e kind_2,

	input rs_station_pkg::prf_tag_t res1_tag,	// result bus 1
	input rs_station_pkg::data_t res1_data,
	input logic res1_valid,
	input rs_station_pkg::prf_tag_t res2_tag,	// result bus 2
	input rs_station_pkg::data_t res2_data,
	input logic res2_valid,

	input logic [rs_station_pkg::NUM_PORTS-1:0] fu_available,
	input logic flush_thread1,
	input logic flush_thread2,

	output logic [rs_station_pkg::NUM_PORTS-1:0] fu_out_valid,
	output rs_station_pkg::data_t [rs_station_pkg::NUM_PORTS-1:0] fu_opa,
	output rs_station_pkg::data_t [rs_station_pkg::NUM_PORTS-1:0] fu_opb,
	output rs_station_pkg::prf_tag_t [rs_station_pkg::NUM_PORTS-1:0] fu_dest,
	output rs_station_pkg::rob_idx_t [rs_station_pkg::NUM_PORTS-1:0] fu_rob_idx,
	output rs_station_pkg::op_type_t [rs_station_pkg::NUM_PORTS-1:0] fu_op_type,
	output logic rs_full,
	output logic rs_one_left
);

	rs_station_pkg::rs_mask_t free_mask;
	rs_station_pkg::rs_mask_t load_mask_1, load_mask_2;
	rs_station_pkg::data_t fwd_opa_1, fwd_opb_1, fwd_opa_2, fwd_opb_2;
	logic fwd_opa_valid_1, fwd_opb_valid_1, fwd_opa_valid_2, fwd_opb_valid_2;
	rs_station_pkg::prf_tag_t ld_dest_1, ld_dest_2;
	rs_station_pkg::rob_idx_t ld_rob_idx_1, ld_rob_idx_2;
	rs_station_pkg::op_type_t ld_op_type_1, ld_op_type_2;
	rs_station_pkg::fu_kind_e ld_kind_1, ld_kind_2;

	rs_result_if i_res_bus ();
	rs_issue_if i_iss_bus ();

	// result buses enter as plain ports
	assign i_res_bus.res1_tag = res1_tag;
	assign i_res_bus.res1_data = res1_data;
	assign i_res_bus.res1_valid = res1_valid;
	assign i_res_bus.res2_tag = res2_tag;
	assign i_res_bus.res2_data = res2_data;
	assign i_res_bus.res2_valid = res2_valid;

	rs_dispatch i_dispatch
	(
		.res(i_res_bus.listen), .free_mask(free_mask),
		.load_1(load_1), .opa_1(opa_1), .opb_1(opb_1),
		.opa_valid_1(opa_valid_1), .opb_valid_1(opb_valid_1),
		.dest_1(dest_1), .rob_idx_1(rob_idx_1), .op_type_1(op_type_1), .kind_1(kind_1),
		.load_2(load_2), .opa_2(opa_2), .opb_2(opb_2),
		.opa_valid_2(opa_valid_2), .opb_valid_2(opb_valid_2),
		.dest_2(dest_2), .rob_idx_2(rob_idx_2), .op_type_2(op_type_2), .kind_2(kind_2),
		.load_mask_1(load_mask_1), .load_mask_2(load_mask_2),
		.fwd_opa_1(fwd_opa_1), .fwd_opb_1(fwd_opb_1),
		.fwd_opa_2(fwd_opa_2), .fwd_opb_2(fwd_opb_2),
		.fwd_opa_valid_1(fwd_opa_valid_1), .fwd_opb_valid_1(fwd_opb_valid_1),
		.fwd_opa_valid_2(fwd_opa_valid_2), .fwd_opb_valid_2(fwd_opb_valid_2),
		.ld_dest_1(ld_dest_1), .ld_rob_idx_1(ld_rob_idx_1),
		.ld_op_type_1(ld_op_type_1), .ld_kind_1(ld_kind_1),
		.ld_dest_2(ld_dest_2), .ld_rob_idx_2(ld_rob_idx_2),
		.ld_op_type_2(ld_op_type_2), .ld_kind_2(ld_kind_2),
		.rs_full(rs_full), .rs_one_left(rs_one_left)
	);

	rs_entry_array i_entry_array
	(
		.clock(clock), .rst_n(rst_n),
		.res(i_res_bus.listen), .iss(i_iss_bus.store),
		.load_mask_1(load_mask_1), .load_mask_2(load_mask_2),
		.fwd_opa_1(fwd_opa_1), .fwd_opb_1(fwd_opb_1),
		.fwd_opa_2(fwd_opa_2), .fwd_opb_2(fwd_opb_2),
		.fwd_opa_valid_1(fwd_opa_valid_1), .fwd_opb_valid_1(fwd_opb_valid_1),
		.fwd_opa_valid_2(fwd_opa_valid_2), .fwd_opb_valid_2(fwd_opb_valid_2),
		.dest_1(ld_dest_1), .rob_idx_1(ld_rob_idx_1),
		.op_type_1(ld_op_type_1), .kind_1(ld_kind_1),
		.dest_2(ld_dest_2), .rob_idx_2(ld_rob_idx_2),
		.op_type_2(ld_op_type_2), .kind_2(ld_kind_2),
		.flush_thread1(flush_thread1), .flush_thread2(flush_thread2),
		.free_mask(free_mask)
	);

	rs_issue_select i_issue_select
	(
		.iss(i_iss_bus.select), .fu_available(fu_available),
		.fu_out_valid(fu_out_valid), .fu_opa(fu_opa), .fu_opb(fu_opb),
		.fu_dest(fu_dest), .fu_rob_idx(fu_rob_idx), .fu_op_type(fu_op_type)
	);

endmodule

//--- logic/rs_station_ifs.sv
// reservation station interfaces

// two result broadcast buses, bus 1 wins on equal tags
interface rs_result_if;
	rs_station_pkg::prf_tag_t res1_tag;
	rs_station_pkg::data_t res1_data;
	logic res1_valid;
	rs_station_pkg::prf_tag_t res2_tag;
	rs_station_pkg::data_t res2_data;
	logic res2_valid;

	modport listen (input res1_tag, res1_data, res1_valid, res2_tag, res2_data, res2_valid);
endinterface

// stored entries towards the issue selector
interface rs_issue_if;
	rs_station_pkg::rs_mask_t ready;	// busy with both operands valid
	rs_station_pkg::fu_kind_e [rs_station_pkg::RS_SIZE-1:0] kind;
	rs_station_pkg::data_t [rs_station_pkg::RS_SIZE-1:0] opa;
	rs_station_pkg::data_t [rs_station_pkg::RS_SIZE-1:0] opb;
	rs_station_pkg::prf_tag_t [rs_station_pkg::RS_SIZE-1:0] dest;
	rs_station_pkg::rob_idx_t [rs_station_pkg::RS_SIZE-1:0] rob_idx;
	rs_station_pkg::op_type_t [rs_station_pkg::RS_SIZE-1:0] op_type;
	rs_station_pkg::rs_mask_t issue_grant;	// strobe, entry freed next edge

	modport store
	(
		output ready, kind, opa, opb, dest, rob_idx, op_type,
		input issue_grant
	);

	modport select
	(
		input ready, kind, opa, opb, dest, rob_idx, op_type,
		output issue_grant
	);
endinterface

//--- logic/rs_station_pkg.sv
// reservation station shared types
package rs_station_pkg;

	////////////////////////////////////////
	// sizes

	localparam int RS_SIZE = 8;	// entries in the station
	localparam int NUM_PORTS = 4;	// issue ports, mult/add/mult/add
	localparam int DATA_W = 64;
	localparam int PRF_TAG_W = 6;
	localparam int ROB_IDX_W = 6;
	localparam int OP_TYPE_W = 6;

	// msb of the rob index tells the thread, 0 is thread 1
	localparam int THREAD_BIT = ROB_IDX_W - 1;

	////////////////////////////////////////
	// field types

	// operand value, holds the source tag in its low bits while not valid
	typedef logic [DATA_W-1:0] data_t;

	typedef logic [PRF_TAG_W-1:0] prf_tag_t;	// physical register tag
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;	// includes the thread bit
	typedef logic [OP_TYPE_W-1:0] op_type_t;	// carried to the unit unchanged
	typedef logic [RS_SIZE-1:0] rs_mask_t;	// one bit per entry

	////////////////////////////////////////
	// unit kinds

	// even ports take multiplies, odd ports take adds
	typedef enum logic
	{
		FU_MULT = 1'b0,
		FU_ADD = 1'b1
	} fu_kind_e;

endpackage

//--- rs_station.f
+incdir+include
logic/rs_station_pkg.sv
logic/rs_station_ifs.sv
logic/rs_dispatch.sv
logic/rs_entry_array.sv
logic/rs_issue_select.sv
logic/rs_station.sv
verif/rs_station_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the reservation station testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f rs_station.f \
	--top-module rs_station_tb -o rs_station_sim
# a failing run exits non-zero, the log search below decides the result
./obj_dir/rs_station_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "Done: no errors" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

//--- include/rs_station_tb_cases.svh
// reservation station test table
`ifndef RS_STATION_TB_CASES_SVH
`define RS_STATION_TB_CASES_SVH

// each start_row opens one cycle with its inputs and the outputs of that cycle
task automatic fill_cases();
	start_row();	// reset state
	// dual dispatch of a mult to entry 0 and an add to entry 1
	start_row();
	put_slot(1, K_MUL, 64'h11, 1'b1, 64'h12, 1'b1, 6'h01, 6'h01);
	put_slot(2, K_ADD, 64'h21, 1'b1, 64'h22, 1'b1, 6'h02, 6'h02);
	start_row();
	want_issue(0, 6'h01, 64'h11);
	want_issue(1, 6'h02, 64'h21);
	start_row();
	// operand tag 10 forwarded from bus 1 at dispatch
	start_row();
	put_slot(1, K_ADD, 64'h10, 1'b0, 64'h5, 1'b1, 6'h03, 6'h03);
	drive_bus(1, 6'h10, 64'haaaa_0001);
	start_row();
	want_issue(1, 6'h03, 64'haaaa_0001);
	// stored entry woken by bus 2
	start_row();
	put_slot(1, K_MUL, 64'h20, 1'b0, 64'h7, 1'b1, 6'h04, 6'h04);
	start_row();
	start_row();
	drive_bus(2, 6'h20, 64'hbbbb_0002);
	start_row();
	want_issue(0, 6'h04, 64'hbbbb_0002);
	// same tag on both buses
	start_row();
	put_slot(1, K_ADD, 64'h30, 1'b0, 64'h9, 1'b1, 6'h05, 6'h05);
	start_row();
	drive_bus(1, 6'h30, 64'hc1);
	drive_bus(2, 6'h30, 64'hc2);
	start_row();
	want_issue(1, 6'h05, 64'hc1);
	////////////////////////////////////////
	// three ready mults held and then issued on ports 0 and 2 only
	start_row();
	gate_ports(4'b0000);
	put_slot(1, K_MUL, 64'h41, 1'b1, 64'h1, 1'b1, 6'h06, 6'h06);
	put_slot(2, K_MUL, 64'h42, 1'b1, 64'h1, 1'b1, 6'h07, 6'h07);
	start_row();
	gate_ports(4'b0000);
	put_slot(1, K_MUL, 64'h43, 1'b1, 64'h1, 1'b1, 6'h08, 6'h08);
	start_row();
	gate_ports(4'b0000);
	start_row();
	gate_ports(4'b0101);
	want_issue(0, 6'h06, 64'h41);
	want_issue(2, 6'h07, 64'h42);
	start_row();
	gate_ports(4'b0101);
	want_issue(0, 6'h08, 64'h43);
	start_row();
	////////////////////////////////////////
	// fill with waiting entries where rob bit 5 picks the thread
	start_row();
	put_slot(1, K_ADD, 64'h38, 1'b0, 64'h0, 1'b1, 6'h10, 6'h08);
	put_slot(2, K_ADD, 64'h39, 1'b0, 64'h0, 1'b1, 6'h11, 6'h28);
	start_row();
	put_slot(1, K_MUL, 64'h3a, 1'b0, 64'h0, 1'b1, 6'h12, 6'h09);
	put_slot(2, K_MUL, 64'h3b, 1'b0, 64'h0, 1'b1, 6'h13, 6'h29);
	start_row();
	put_slot(1, K_ADD, 64'h3c, 1'b0, 64'h0, 1'b1, 6'h14, 6'h0a);
	put_slot(2, K_ADD, 64'h3d, 1'b0, 64'h0, 1'b1, 6'h15, 6'h2a);
	start_row();
	put_slot(1, K_MUL, 64'h3e, 1'b0, 64'h0, 1'b1, 6'h16, 6'h0b);
	start_row();
	want_flags(1'b0, 1'b1);	// seven busy
	start_row();
	want_flags(1'b0, 1'b1);
	put_slot(1, K_MUL, 64'h3f, 1'b0, 64'h0, 1'b1, 6'h17, 6'h2b);
	start_row();
	want_flags(1'b1, 1'b0);
	// flush thread 1 so that its tags wake nothing
	start_row();
	want_flags(1'b1, 1'b0);
	flush_threads(1'b1, 1'b0);
	start_row();
	start_row();
	drive_bus(1, 6'h38, 64'he0);
	drive_bus(2, 6'h3a, 64'he2);
	start_row();
	drive_bus(1, 6'h3c, 64'he4);
	drive_bus(2, 6'h3e, 64'he6);
	start_row();
	drive_bus(1, 6'h39, 64'hd9);
	drive_bus(2, 6'h3b, 64'hdb);
	start_row();
	want_issue(0, 6'h13, 64'hdb);
	want_issue(1, 6'h11, 64'hd9);
	drive_bus(1, 6'h3d, 64'hdd);
	drive_bus(2, 6'h3f, 64'hdf);
	start_row();
	want_issue(0, 6'h17, 64'hdf);
	want_issue(1, 6'h15, 64'hdd);
	start_row();
endtask

`endif

//--- verif/rs_station_tb.sv
// reservation station testbench
module rs_station_tb;

	localparam int MAX_ROWS = 64;
	localparam int RESET_TIMEOUT = 50;	// cycles
	localparam int NUM_TAGS = 1 << rs_station_pkg::PRF_TAG_W;
	localparam rs_station_pkg::fu_kind_e K_MUL = rs_station_pkg::FU_MULT;
	localparam rs_station_pkg::fu_kind_e K_ADD = rs_station_pkg::FU_ADD;

	// one dispatch slot as seen on the top level ports
	typedef struct packed
	{
		logic load;
		rs_station_pkg::data_t opa;
		logic opa_valid;
		rs_station_pkg::data_t opb;
		logic opb_valid;
		rs_station_pkg::prf_tag_t dest;
		rs_station_pkg::rob_idx_t rob_idx;
		rs_station_pkg::op_type_t op_type;
		rs_station_pkg::fu_kind_e kind;
	} slot_t;

	typedef struct packed
	{
		logic valid;
		rs_station_pkg::prf_tag_t tag;
		rs_station_pkg::data_t data;
	} bus_t;

	logic clock;
	logic rst_n;
	slot_t slot_in [2];
	bus_t bus_in [2];	// result buses 1 and 2
	logic [rs_station_pkg::NUM_PORTS-1:0] fu_available;
	logic flush_thread1;
	logic flush_thread2;
	logic [rs_station_pkg::NUM_PORTS-1:0] fu_out_valid;
	rs_station_pkg::data_t [rs_station_pkg::NUM_PORTS-1:0] fu_opa;
	rs_station_pkg::data_t [rs_station_pkg::NUM_PORTS-1:0] fu_opb;
	rs_station_pkg::prf_tag_t [rs_station_pkg::NUM_PORTS-1:0] fu_dest;
	rs_station_pkg::rob_idx_t [rs_station_pkg::NUM_PORTS-1:0] fu_rob_idx;
	rs_station_pkg::op_type_t [rs_station_pkg::NUM_PORTS-1:0] fu_op_type;
	logic rs_full;
	logic rs_one_left;

	////////////////////////////////////////
	// case table, one row per cycle

	slot_t slot_tab [MAX_ROWS][2];
	bus_t bus_tab [MAX_ROWS][2];
	logic [rs_station_pkg::NUM_PORTS-1:0] avail_tab [MAX_ROWS];
	logic [1:0] flush_tab [MAX_ROWS];
	logic [rs_station_pkg::NUM_PORTS-1:0] valid_exp [MAX_ROWS];
	rs_station_pkg::prf_tag_t dest_exp [MAX_ROWS][rs_station_pkg::NUM_PORTS];
	rs_station_pkg::data_t opa_exp [MAX_ROWS][rs_station_pkg::NUM_PORTS];
	rs_station_pkg::data_t opb_exp [MAX_ROWS][rs_station_pkg::NUM_PORTS];
	rs_station_pkg::rob_idx_t rob_exp [MAX_ROWS][rs_station_pkg::NUM_PORTS];
	rs_station_pkg::op_type_t op_type_exp [MAX_ROWS][rs_station_pkg::NUM_PORTS];
	logic full_exp [MAX_ROWS];
	logic one_left_exp [MAX_ROWS];
	int n_rows = 0;
	int row;	// row being filled

	// fields of each dispatched instruction by its destination tag
	rs_station_pkg::data_t opb_sent [NUM_TAGS];
	rs_station_pkg::rob_idx_t rob_sent [NUM_TAGS];
	rs_station_pkg::op_type_t op_type_sent [NUM_TAGS];

	rs_station i_rs_station
	(
		.clock(clock), .rst_n(rst_n),
		.load_1(slot_in[0].load), .opa_1(slot_in[0].opa), .opb_1(slot_in[0].opb),
		.opa_valid_1(slot_in[0].opa_valid), .opb_valid_1(slot_in[0].opb_valid),
		.dest_1(slot_in[0].dest), .rob_idx_1(slot_in[0].rob_idx),
		.op_type_1(slot_in[0].op_type), .kind_1(slot_in[0].kind),
		.load_2(slot_in[1].load), .opa_2(slot_in[1].opa), .opb_2(slot_in[1].opb),
		.opa_valid_2(slot_in[1].opa_valid), .opb_valid_2(slot_in[1].opb_valid),
		.dest_2(slot_in[1].dest), .rob_idx_2(slot_in[1].rob_idx),
		.op_type_2(slot_in[1].op_type), .kind_2(slot_in[1].kind),
		.res1_tag(bus_in[0].tag), .res1_data(bus_in[0].data), .res1_valid(bus_in[0].valid),
		.res2_tag(bus_in[1].tag), .res2_data(bus_in[1].data), .res2_valid(bus_in[1].valid),
		.fu_available(fu_available),
		.flush_thread1(flush_thread1), .flush_thread2(flush_thread2),
		.fu_out_valid(fu_out_valid), .fu_opa(fu_opa), .fu_opb(fu_opb), .fu_dest(fu_dest),
		.fu_rob_idx(fu_rob_idx), .fu_op_type(fu_op_type),
		.rs_full(rs_full), .rs_one_left(rs_one_left)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	initial
	begin
		rst_n = 1'b0;
		repeat (8) @(posedge clock);
		#5;
		rst_n = 1'b1;
	end

	////////////////////////////////////////
	// row building

	task automatic start_row();
		row = n_rows;
		n_rows++;
		slot_tab[row][0] = '0;
		slot_tab[row][1] = '0;
		bus_tab[row][0] = '0;
		bus_tab[row][1] = '0;
		avail_tab[row] = '1;	// all ports free unless a row says otherwise
		flush_tab[row] = 2'b00;
		valid_exp[row] = '0;
		full_exp[row] = 1'b0;
		one_left_exp[row] = 1'b0;
		for (int p = 0; p < rs_station_pkg::NUM_PORTS; p++)
		begin
			dest_exp[row][p] = '0;	// idle ports read zero
			opa_exp[row][p] = '0;
			opb_exp[row][p] = '0;
			rob_exp[row][p] = '0;
			op_type_exp[row][p] = '0;
		end
	endtask

	task automatic put_slot(input int s, input rs_station_pkg::fu_kind_e kind,
		input rs_station_pkg::data_t a, input logic a_valid,
		input rs_station_pkg::data_t b, input logic b_valid,
		input rs_station_pkg::prf_tag_t dest, input rs_station_pkg::rob_idx_t rob);
		slot_tab[row][s-1].load = 1'b1;
		slot_tab[row][s-1].kind = kind;
		slot_tab[row][s-1].opa = a;
		slot_tab[row][s-1].opa_valid = a_valid;
		slot_tab[row][s-1].opb = b;
		slot_tab[row][s-1].opb_valid = b_valid;
		slot_tab[row][s-1].dest = dest;
		slot_tab[row][s-1].rob_idx = rob;
		slot_tab[row][s-1].op_type = dest ^ 6'h15;	// arbitrary code
		opb_sent[dest] = b;
		rob_sent[dest] = rob;
		op_type_sent[dest] = slot_tab[row][s-1].op_type;
	endtask

	task automatic drive_bus(input int b, input rs_station_pkg::prf_tag_t tag,
		input rs_station_pkg::data_t data);
		bus_tab[row][b-1].valid = 1'b1;
		bus_tab[row][b-1].tag = tag;
		bus_tab[row][b-1].data = data;
	endtask

	task automatic gate_ports(input logic [rs_station_pkg::NUM_PORTS-1:0] mask);
		avail_tab[row] = mask;
	endtask

	task automatic flush_threads(input logic t1, input logic t2);
		flush_tab[row] = {t2, t1};
	endtask

	// the other fields come unchanged from the dispatch with this dest
	task automatic want_issue(input int p, input rs_station_pkg::prf_tag_t dest,
		input rs_station_pkg::data_t opa);
		valid_exp[row][p] = 1'b1;
		dest_exp[row][p] = dest;
		opa_exp[row][p] = opa;
		opb_exp[row][p] = opb_sent[dest];
		rob_exp[row][p] = rob_sent[dest];
		op_type_exp[row][p] = op_type_sent[dest];
	endtask

	task automatic want_flags(input logic full, input logic one_left);
		full_exp[row] = full;
		one_left_exp[row] = one_left;
	endtask

	`include "rs_station_tb_cases.svh"

	////////////////////////////////////////
	// compares

	task automatic stop_on_error(input string msg);
		$display("[FAIL] t=%0t %s", $time, msg);
		$display("Done: errors found");
		$fatal(1, "output mismatch");
	endtask

	task automatic check_valid(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic check_tag(input rs_station_pkg::prf_tag_t got,
		input rs_station_pkg::prf_tag_t exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_data(input rs_station_pkg::data_t got,
		input rs_station_pkg::data_t exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_rob(input rs_station_pkg::rob_idx_t got,
		input rs_station_pkg::rob_idx_t exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_op_type(input rs_station_pkg::op_type_t got,
		input rs_station_pkg::op_type_t exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic apply_row(input int r);
		slot_in[0] = slot_tab[r][0];
		slot_in[1] = slot_tab[r][1];
		bus_in[0] = bus_tab[r][0];
		bus_in[1] = bus_tab[r][1];
		fu_available = avail_tab[r];
		flush_thread1 = flush_tab[r][0];
		flush_thread2 = flush_tab[r][1];
	endtask

	task automatic check_row(input int r);
		string where;
		for (int p = 0; p < rs_station_pkg::NUM_PORTS; p++)
		begin
			where = $sformatf("row %0d port %0d", r, p);
			check_valid(fu_out_valid[p], valid_exp[r][p], {where, " valid"});
			check_tag(fu_dest[p], dest_exp[r][p], {where, " dest"});
			check_data(fu_opa[p], opa_exp[r][p], {where, " opa"});
			check_data(fu_opb[p], opb_exp[r][p], {where, " opb"});
			check_rob(fu_rob_idx[p], rob_exp[r][p], {where, " rob_idx"});
			check_op_type(fu_op_type[p], op_type_exp[r][p], {where, " op_type"});
		end
		check_flag(rs_full, full_exp[r], $sformatf("row %0d rs_full", r));
		check_flag(rs_one_left, one_left_exp[r], $sformatf("row %0d rs_one_left", r));
	endtask

	initial
	begin
		int waited;
		slot_in[0] = '0;
		slot_in[1] = '0;
		bus_in[0] = '0;
		bus_in[1] = '0;
		fu_available = '0;
		flush_thread1 = 1'b0;
		flush_thread2 = 1'b0;
		fill_cases();
		waited = 0;
		while (rst_n !== 1'b1 && waited < RESET_TIMEOUT)
		begin
			@(posedge clock);
			waited++;
		end
		if (rst_n !== 1'b1)
		begin
			$display("reset was not released within %0d cycles", RESET_TIMEOUT);
			$display("Done: errors found");
			$fatal(1, "reset timeout");
		end
		else
		begin
			// drive just after the edge and sample just before the next one
			for (int r = 0; r < n_rows; r++)
			begin
				#5;
				apply_row(r);
				#30;
				check_row(r);
				@(posedge clock);
			end
			$display("Done: no errors");
			$finish;
		end
	end

endmodule
